// ==== Bender.yml ====
package:
  name: pipeline_ctrl

export_include_dirs:
  - source

sources:
  - source/rv_pipe_pkg.sv
  - source/fetch_pc.sv
  - source/if_ex_latch.sv
  - source/hazard_unit.sv
  - source/prv_exception.sv
  - source/pipeline_ctrl.sv
  - target: test
    files:
      - dv/pipeline_ctrl_checker.sv
      - dv/pipeline_ctrl_assertions.sv
      - dv/pipeline_ctrl_tb.sv

// ==== all.f ====
+incdir+source
source/rv_pipe_pkg.sv
source/fetch_pc.sv
source/if_ex_latch.sv
source/hazard_unit.sv
source/prv_exception.sv
source/pipeline_ctrl.sv
dv/pipeline_ctrl_checker.sv
dv/pipeline_ctrl_assertions.sv
dv/pipeline_ctrl_tb.sv

// ==== dv/pipeline_ctrl_assertions.sv ====
//==========================================================
// Pipeline control assertions.
// Hazard unit and PC rules, bound into the top level.
//==========================================================
`include "rv_pipe_macros.svh"
`default_nettype none

module pipeline_ctrl_assertions (
  input wire logic               clk,
  input wire logic               rst,
  input wire rv_pipe_pkg::addr_t pc,
  input wire rv_pipe_pkg::addr_t ex_target,
  input wire logic               ex_valid,
  input wire logic               intr,
  input wire logic               npc_sel
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;   // Failed assertion count.

  // A taken trap always moves the stage register on, even under a stall.
  trap_flushes_stage: assert property (@(posedge clk) disable iff (rst)
      intr |=> !ex_valid && pc == `TRAP_PC)
    else begin
      $error("Trap taken but the stage register was not flushed or PC not at the trap vector.");
      fail_count++;
    end

  reset_loads_pc: assert property (@(posedge clk) rst |=> pc == `RESET_PC)
    else begin
      $error("PC is not the reset vector in the cycle after reset.");
      fail_count++;
    end

  // Redirect without a trap lands on the execute-stage target.
  redirect_loads_target: assert property (@(posedge clk) disable iff (rst)
      npc_sel && !intr |=> pc == $past(ex_target))
    else begin
      $error("Redirect selected but the PC did not load the target.");
      fail_count++;
    end

endmodule

bind pipeline_ctrl pipeline_ctrl_assertions pipeline_ctrl_assertions_i (
  .clk(clk), .rst(rst), .pc(pc), .ex_target(ex_target), .ex_valid(ex_valid),
  .intr(intr), .npc_sel(npc_sel)
);

`default_nettype wire

// ==== dv/pipeline_ctrl_checker.sv ====
//==========================================================
// Pipeline control checker.
// Compares the DUT outputs with the vector's expected values
// after each edge and counts the mismatches.
//==========================================================
`include "rv_pipe_macros.svh"
`default_nettype none

module pipeline_ctrl_checker (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                check_en,      // A vector was applied this cycle.
  input  wire logic [159:0]        test_name,
  input  wire rv_pipe_pkg::addr_t  exp_pc,
  input  wire logic                exp_ex_valid,
  input  wire rv_pipe_pkg::addr_t  exp_ex_pc,
  input  wire rv_pipe_pkg::cause_t exp_cause,
  input  wire rv_pipe_pkg::addr_t  exp_epc,
  input  wire rv_pipe_pkg::word_t  imem_data,
  input  wire logic                irq,
  input  wire rv_pipe_pkg::addr_t  pc,
  input  wire logic                iren,
  input  wire rv_pipe_pkg::word_t  ex_instr,
  input  wire logic                ex_valid,
  input  wire rv_pipe_pkg::addr_t  ex_pc,
  input  wire rv_pipe_pkg::cause_t trap_cause,
  input  wire rv_pipe_pkg::addr_t  trap_epc,
  input  wire logic                pipeline_finish,
  output int                       checks,
  output int                       errors
);
  timeunit 1ns;
  timeprecision 100ps;

  logic               armed = 1'b0;
  logic [159:0]       name_q;
  rv_pipe_pkg::addr_t pc_q;
  logic               valid_q;
  rv_pipe_pkg::addr_t ex_pc_q;
  rv_pipe_pkg::cause_t cause_q;
  rv_pipe_pkg::addr_t epc_q;
  rv_pipe_pkg::addr_t cur_pc_q;     // Expected fetch address while a vector is applied.
  rv_pipe_pkg::word_t instr_q;      // Word expected in the execute slot.
  int                 n_checks = 0;
  int                 n_errors = 0;

  assign checks = n_checks;
  assign errors = n_errors;

  task automatic check_value(input logic [159:0] name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("FAILED %0s %0s: expected %h, actual %h", name, field, expected, actual);
    end
  endtask

  // Expected values are stable at the edge, so grab them here.
  always @(posedge clk) begin
    armed   <= check_en & ~rst;
    name_q  <= test_name;
    pc_q    <= exp_pc;
    valid_q <= exp_ex_valid;
    ex_pc_q <= exp_ex_pc;
    cause_q <= exp_cause;
    epc_q   <= exp_epc;
    if (rst) begin
      cur_pc_q <= rv_pipe_pkg::addr_t'(`RESET_PC);
    end else if (check_en) begin
      cur_pc_q <= exp_pc;
      // Slot now holds this fetch, so it carries this cycle's word.
      if (exp_ex_valid && exp_ex_pc == cur_pc_q) begin
        instr_q <= imem_data;
      end
    end
  end

  // Mid-cycle compare, well clear of the edge.
  always @(negedge clk) begin
    if (rst) begin
      check_value("reset", "pc", `RESET_PC, pc);
      check_value("reset", "ex_valid", 32'd0, ex_valid);
      check_value("reset", "trap_cause", 32'd0, trap_cause);
      check_value("reset", "trap_epc", 32'd0, trap_epc);
      check_value("reset", "iren", 32'd0, iren);        // Fetch is off in reset.
    end else if (armed) begin
      check_value(name_q, "pc", pc_q, pc);
      check_value(name_q, "ex_valid", valid_q, ex_valid);
      if (valid_q) check_value(name_q, "ex_pc", ex_pc_q, ex_pc);   // Bubble payload is free.
      if (valid_q) check_value(name_q, "ex_instr", instr_q, ex_instr);
      check_value(name_q, "trap_cause", cause_q, trap_cause);
      check_value(name_q, "trap_epc", epc_q, trap_epc);
      check_value(name_q, "iren", 32'd1, iren);
      check_value(name_q, "pipeline_finish", irq, pipeline_finish);
    end
  end

endmodule

`default_nettype wire

// ==== dv/pipeline_ctrl_tb.sv ====
//==========================================================
// Pipeline control testbench.
// Clock, reset, vectors from the test file, timeout and the
// closing report.
//==========================================================
`default_nettype none

module pipeline_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_MARGIN = 20;   // Spare cycles over the vector count.
  localparam int NUM_FIELDS     = 18;   // Name, 12 inputs, 5 expected values.

  logic                    clk;
  logic                    rst;
  rv_pipe_pkg::word_t      imem_data;
  logic                    i_ram_busy;
  logic                    d_ram_busy;
  logic                    dren;
  logic                    dwen;
  logic                    jump;
  logic                    branch;
  logic                    mispredict;
  logic                    halt;
  rv_pipe_pkg::addr_t      ex_target;
  rv_pipe_pkg::exc_flags_t ex_flags;
  logic                    irq;
  rv_pipe_pkg::addr_t      pc;
  logic                    iren;
  rv_pipe_pkg::word_t      ex_instr;
  rv_pipe_pkg::addr_t      ex_pc;
  logic                    ex_valid;
  rv_pipe_pkg::cause_t     trap_cause;
  rv_pipe_pkg::addr_t      trap_epc;
  logic                    pipeline_finish;

  // Expected values for after the next edge.
  logic                    check_en;
  logic [159:0]            test_name;    // Up to 20 characters.
  rv_pipe_pkg::addr_t      exp_pc;
  logic                    exp_ex_valid;
  rv_pipe_pkg::addr_t      exp_ex_pc;
  rv_pipe_pkg::cause_t     exp_cause;
  rv_pipe_pkg::addr_t      exp_epc;
  int                      checks;
  int                      errors;

  string                   lines[$];     // Lines that parse as a full vector.
  int                      cycles = 0;
  int                      max_cycles = TIMEOUT_MARGIN;

  pipeline_ctrl pipeline_ctrl_i (.*);

  pipeline_ctrl_checker checker_i (.*);

  // Parses one line straight onto the DUT inputs and expected values.
  task automatic load_vector(input string text, output int fields);
    fields = $sscanf(text, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     test_name, imem_data, i_ram_busy, d_ram_busy, dren, dwen, jump,
                     branch, mispredict, halt, ex_target, ex_flags, irq,
                     exp_pc, exp_ex_valid, exp_ex_pc, exp_cause, exp_epc);
  endtask

  task automatic drive_idle();
    {i_ram_busy, d_ram_busy, dren, dwen} = 4'b0000;
    {jump, branch, mispredict, halt, irq} = 5'b00000;
    imem_data = '0;
    ex_target = '0;
    ex_flags  = '0;
    check_en  = 1'b0;      // Nothing to compare yet.
    test_name = '0;
    {exp_pc, exp_ex_valid, exp_ex_pc, exp_cause, exp_epc} = '0;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Bounded run, limit set once the vectors are counted.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Run timed out after %0d cycles without finishing the vectors.", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    int    fd;
    int    fields;
    int    assert_fails;
    string line;
    rst = 1'b1;
    drive_idle();
    fd = $fopen("dv/pipeline_ctrl_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test vector file.");
      $display("TB FAILED");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0) begin
          load_vector(line, fields);
          if (fields == NUM_FIELDS) lines.push_back(line);   // Comment lines fall out here.
        end
      end
      $fclose(fd);
      drive_idle();
      max_cycles = lines.size() + TIMEOUT_MARGIN;
      if (lines.size() == 0) begin
        $display("The test vector file holds no vectors.");
        $display("TB FAILED");
        $finish;
      end else begin
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (lines[i]) begin
          load_vector(lines[i], fields);
          check_en = 1'b1;
          @(posedge clk);
          #1;              // Next vector lands just after the edge.
        end
        check_en = 1'b0;
        @(negedge clk);    // Last comparison.
        #1;
        assert_fails = pipeline_ctrl_i.pipeline_ctrl_assertions_i.fail_count;
        $display("Vectors: %0d, checks: %0d, errors: %0d, assertion failures: %0d.",
                 lines.size(), checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
          $display("TB PASSED");
        end else begin
          $display("TB FAILED");
        end
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/pipeline_ctrl_tests.txt ====
# test imem ibusy dbusy dren dwen jump branch mispred halt target flags irq | pc valid ex_pc cause epc
# All fields hex, expected values hold after the next edge, ex_pc only checked when valid is 1.
seq_a           00000013 0 0 0 0 0 0 0 0 00000000 000 0 00000204 1 00000200 0 00000000
seq_b           00100093 0 0 0 0 0 0 0 0 00000000 000 0 00000208 1 00000204 0 00000000
dmem_wait       00200113 0 1 1 0 0 0 0 0 00000000 000 0 00000208 1 00000204 0 00000000
imem_wait       00300193 1 0 0 0 0 0 0 0 00000000 000 0 00000208 1 00000204 0 00000000
halt_hold       00400213 0 0 0 0 0 0 0 1 00000000 000 0 00000208 1 00000204 0 00000000
resume          00500293 0 0 0 0 0 0 0 0 00000000 000 0 0000020c 1 00000208 0 00000000
imem_after_data 00600313 1 0 0 1 0 0 0 0 00000000 000 0 0000020c 0 00000000 0 00000000
refill          00700393 0 0 0 0 0 0 0 0 00000000 000 0 00000210 1 0000020c 0 00000000
jump            0000006f 0 0 0 0 1 0 0 0 00000300 000 0 00000300 0 00000000 0 00000000
after_jump      00800413 0 0 0 0 0 0 0 0 00000000 000 0 00000304 1 00000300 0 00000000
br_mispredict   00000063 0 0 0 0 0 1 1 0 00000400 000 0 00000400 0 00000000 0 00000000
after_branch    00900493 0 0 0 0 0 0 0 0 00000000 000 0 00000404 1 00000400 0 00000000
br_predicted    00000063 0 0 0 0 0 1 0 0 00000500 000 0 00000408 1 00000404 0 00000000
exc_illegal     ffffffff 0 0 0 0 0 0 0 0 00000000 040 0 00000100 0 00000000 2 00000404
trap_refill     00a00513 0 0 0 0 0 0 0 0 00000000 000 0 00000104 1 00000100 2 00000404
exc_two_bits    00100073 0 0 0 0 0 0 0 0 00000000 028 0 00000100 0 00000000 3 00000100
exc_on_bubble   00b00593 0 0 0 0 0 0 0 0 00000000 100 0 00000104 1 00000100 3 00000100
exc_fault_first 00c00613 0 0 0 0 0 0 0 0 00000000 101 0 00000100 0 00000000 1 00000100
irq_pulse       0000006f 0 0 0 0 1 0 0 0 00000600 000 1 00000600 0 00000000 1 00000100
irq_halted      00d00693 0 0 0 0 0 0 0 1 00000000 000 0 00000600 0 00000000 1 00000100
irq_refill      00e00713 0 0 0 0 0 0 0 0 00000000 000 0 00000604 1 00000600 1 00000100
irq_over_stall  00f00793 0 0 0 0 0 0 0 1 00000000 000 0 00000100 0 00000000 f 00000600
irq_cleared     01000813 0 0 0 0 0 0 0 0 00000000 000 0 00000104 1 00000100 f 00000600
irq_done        01100893 0 0 0 0 0 0 0 0 00000000 000 0 00000108 1 00000104 f 00000600

// ==== source/fetch_pc.sv ====
//==========================================================
// Fetch program counter.
// Holds the PC and selects trap, redirect or sequential next.
//==========================================================
`include "rv_pipe_macros.svh"
`default_nettype none

module fetch_pc (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               pc_en,      // Advance to the next word.
  input  wire logic               npc_sel,    // Take the execute-stage target.
  input  wire logic               intr,       // Trap taken this cycle.
  input  wire rv_pipe_pkg::addr_t ex_target,
  output rv_pipe_pkg::addr_t      pc
);

  rv_pipe_pkg::addr_t pc_next;

  // Trap wins over redirect, redirect over the sequential step.
  always_comb begin
    if (intr) begin
      pc_next = rv_pipe_pkg::addr_t'(`TRAP_PC);
    end else if (npc_sel) begin
      pc_next = ex_target;                        // Jump or mispredicted branch.
    end else if (pc_en) begin
      pc_next = pc + rv_pipe_pkg::addr_t'(`PC_STEP);
    end else begin
      pc_next = pc;                               // Memory wait or halt.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= rv_pipe_pkg::addr_t'(`RESET_PC);
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// ==== source/hazard_unit.sv ====
//==========================================================
// Hazard unit.
// Stall, flush, PC enable and redirect for the two-stage
// pipeline, from memory waits, jumps, halt and traps.
//==========================================================
`default_nettype none

module hazard_unit (
  input  wire logic iren,
  input  wire logic i_ram_busy,
  input  wire logic d_ram_busy,
  input  wire logic dren,         // Execute stage loads.
  input  wire logic dwen,         // Execute stage stores.
  input  wire logic jump,
  input  wire logic branch,
  input  wire logic mispredict,
  input  wire logic halt,
  input  wire logic intr,         // Trap from the privilege block.
  output logic      npc_sel,
  output logic      pc_en,
  output logic      if_ex_flush,
  output logic      if_ex_stall
);

  logic dmem_access;
  logic branch_jump;
  logic wait_for_imem;
  logic wait_for_dmem;

  assign dmem_access   = dren | dwen;
  assign branch_jump   = jump | (branch & mispredict);  // Predicted branches fall through.
  assign wait_for_imem = iren & i_ram_busy;
  assign wait_for_dmem = dmem_access & d_ram_busy;

  // Redirect to the execute-stage target.
  assign npc_sel = branch_jump;

  // PC moves when nothing waits, or on a redirect.
  assign pc_en = (~wait_for_dmem & ~wait_for_imem & ~halt) | branch_jump;

  // The data access finished but fetch is still busy.
  // Let the load or store retire and drop the fetch slot.
  assign if_ex_flush = intr | branch_jump |
                       (wait_for_imem & dmem_access & ~d_ram_busy);

  // Hold execute on a memory wait or halt.
  // A trap always moves on, so intr overrides the stall.
  assign if_ex_stall = (wait_for_dmem | (wait_for_imem & ~dmem_access) | halt) &
                       ~intr;

endmodule

`default_nettype wire

// ==== source/if_ex_latch.sv ====
//==========================================================
// Fetch to execute pipeline register.
// Instruction, its PC and a valid bit, with stall and flush.
//==========================================================
`default_nettype none

module if_ex_latch (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               stall,     // Freeze the entry.
  input  wire logic               flush,     // Kill the entry, beats stall.
  input  wire rv_pipe_pkg::word_t instr_in,
  input  wire rv_pipe_pkg::addr_t pc_in,
  output rv_pipe_pkg::word_t      ex_instr,
  output rv_pipe_pkg::addr_t      ex_pc,
  output logic                    ex_valid
);

  // Valid bit.
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (flush) begin
      ex_valid <= 1'b0;                 // Squashed slot becomes a bubble.
    end else if (!stall) begin
      ex_valid <= 1'b1;
    end
  end

  // Payload only moves when not stalled.
  // A flushed slot may load anything, valid is already low.
  always_ff @(posedge clk) begin
    if (!stall) begin
      ex_instr <= instr_in;
      ex_pc    <= pc_in;
    end
  end

endmodule

`default_nettype wire

// ==== source/pipeline_ctrl.sv ====
//==========================================================
// Two-stage pipeline control top.
// Connects fetch PC, stage register, hazard unit and the
// privilege exception block.
//==========================================================
`default_nettype none

module pipeline_ctrl (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire rv_pipe_pkg::word_t      imem_data,   // Fetched instruction.
  input  wire logic                    i_ram_busy,
  input  wire logic                    d_ram_busy,
  input  wire logic                    dren,
  input  wire logic                    dwen,
  input  wire logic                    jump,
  input  wire logic                    branch,
  input  wire logic                    mispredict,
  input  wire logic                    halt,
  input  wire rv_pipe_pkg::addr_t      ex_target,
  input  wire rv_pipe_pkg::exc_flags_t ex_flags,
  input  wire logic                    irq,
  output rv_pipe_pkg::addr_t           pc,
  output logic                         iren,
  output rv_pipe_pkg::word_t           ex_instr,
  output rv_pipe_pkg::addr_t           ex_pc,
  output logic                         ex_valid,
  output rv_pipe_pkg::cause_t          trap_cause,
  output rv_pipe_pkg::addr_t           trap_epc,
  output logic                         pipeline_finish
);

  logic npc_sel;
  logic pc_en;
  logic if_ex_flush;
  logic if_ex_stall;
  logic intr;

  assign iren            = ~rst;   // Fetch runs whenever out of reset.
  assign pipeline_finish = irq;    // Mirrors the interrupt request.

  fetch_pc fetch_pc_i (
    .clk       (clk),
    .rst       (rst),
    .pc_en     (pc_en),
    .npc_sel   (npc_sel),
    .intr      (intr),
    .ex_target (ex_target),
    .pc        (pc)
  );

  // Stage register, loads the word fetched at pc.
  if_ex_latch if_ex_latch_i (
    .clk      (clk),
    .rst      (rst),
    .stall    (if_ex_stall),
    .flush    (if_ex_flush),
    .instr_in (imem_data),
    .pc_in    (pc),
    .ex_instr (ex_instr),
    .ex_pc    (ex_pc),
    .ex_valid (ex_valid)
  );

  hazard_unit hazard_unit_i (
    .iren        (iren),
    .i_ram_busy  (i_ram_busy),
    .d_ram_busy  (d_ram_busy),
    .dren        (dren),
    .dwen        (dwen),
    .jump        (jump),
    .branch      (branch),
    .mispredict  (mispredict),
    .halt        (halt),
    .intr        (intr),
    .npc_sel     (npc_sel),
    .pc_en       (pc_en),
    .if_ex_flush (if_ex_flush),
    .if_ex_stall (if_ex_stall)
  );

  prv_exception prv_exception_i (
    .clk        (clk),
    .rst        (rst),
    .ex_valid   (ex_valid),
    .ex_flags   (ex_flags),
    .ex_pc      (ex_pc),
    .irq        (irq),
    .intr       (intr),
    .trap_cause (trap_cause),
    .trap_epc   (trap_epc)
  );

endmodule

`default_nettype wire

// ==== source/prv_exception.sv ====
//==========================================================
// Privilege exception block.
// Ranks exceptions, holds a pending interrupt, records the
// trap cause and EPC and raises intr.
//==========================================================
`include "rv_pipe_macros.svh"
`default_nettype none

module prv_exception (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    ex_valid,   // Execute slot holds a real instruction.
  input  wire rv_pipe_pkg::exc_flags_t ex_flags,
  input  wire rv_pipe_pkg::addr_t      ex_pc,
  input  wire logic                    irq,        // External interrupt request.
  output logic                         intr,
  output rv_pipe_pkg::cause_t          trap_cause,
  output rv_pipe_pkg::addr_t           trap_epc
);

  rv_pipe_pkg::exc_flags_t flags;
  rv_pipe_pkg::cause_t     exc_cause;
  rv_pipe_pkg::cause_t     cause_next;
  logic                    exc_any;
  logic                    irq_pending;
  logic                    irq_taken;

  // Bubbles never raise an exception.
  assign flags   = ex_valid ? ex_flags : '0;
  assign exc_any = |flags;

  // Fixed priority, bit 8 highest.
  always_comb begin
    if (flags[8]) begin
      exc_cause = `CAUSE_FAULT_INSN;
    end else if (flags[7]) begin
      exc_cause = `CAUSE_MAL_INSN;
    end else if (flags[6]) begin
      exc_cause = `CAUSE_ILLEGAL_INSN;
    end else if (flags[5]) begin
      exc_cause = `CAUSE_BREAKPOINT;
    end else if (flags[4]) begin
      exc_cause = `CAUSE_ENV_M;
    end else if (flags[3]) begin
      exc_cause = `CAUSE_MAL_L;
    end else if (flags[2]) begin
      exc_cause = `CAUSE_FAULT_L;
    end else if (flags[1]) begin
      exc_cause = `CAUSE_MAL_S;
    end else begin
      exc_cause = `CAUSE_FAULT_S;   // Only used when bit 0 is set.
    end
  end

  // Synchronous exceptions win over a pending interrupt.
  assign intr       = ex_valid & (exc_any | irq_pending);
  assign irq_taken  = intr & ~exc_any;
  assign cause_next = exc_any ? exc_cause : `CAUSE_IRQ;

  // Interrupt stays pending until it is the trap that gets taken.
  always_ff @(posedge clk) begin
    if (rst) begin
      irq_pending <= 1'b0;
    end else if (irq_taken) begin
      irq_pending <= 1'b0;
    end else if (irq) begin
      irq_pending <= 1'b1;
    end
  end

  // Cause and EPC of the last taken trap.
  always_ff @(posedge clk) begin
    if (rst) begin
      trap_cause <= '0;
      trap_epc   <= '0;
    end else if (intr) begin
      trap_cause <= cause_next;
      trap_epc   <= ex_pc;      // Faulting or interrupted instruction.
    end
  end

endmodule

`default_nettype wire

// ==== source/rv_pipe_macros.svh ====
//==========================================================
// RV pipeline constants.
// Reset and trap vectors, PC step and trap cause codes.
//==========================================================
`ifndef RV_PIPE_MACROS_SVH
`define RV_PIPE_MACROS_SVH

`define RESET_PC 32'h0000_0200   // First fetch address after reset.
`define TRAP_PC  32'h0000_0100   // Single trap vector, no vectored mode.
`define PC_STEP  32'd4           // One 32-bit instruction.

// Standard machine cause codes, one per exception bit.
`define CAUSE_MAL_INSN     4'd0
`define CAUSE_FAULT_INSN   4'd1
`define CAUSE_ILLEGAL_INSN 4'd2
`define CAUSE_BREAKPOINT   4'd3
`define CAUSE_MAL_L        4'd4
`define CAUSE_FAULT_L      4'd5
`define CAUSE_MAL_S        4'd6
`define CAUSE_FAULT_S      4'd7
`define CAUSE_ENV_M        4'd11
`define CAUSE_IRQ          4'd15  // Reserved code, marks the external interrupt.

`endif

// ==== source/rv_pipe_pkg.sv ====
//==========================================================
// RV pipeline types.
// Width typedefs shared by the pipeline control blocks.
//==========================================================
`default_nettype none

package rv_pipe_pkg;

  typedef logic [31:0] word_t;   // Instruction word or branch target.
  typedef logic [31:0] addr_t;   // Instruction address.

  // One bit per exception, highest priority first.
  // [8] fault_insn
  // [7] mal_insn
  // [6] illegal_insn
  // [5] breakpoint
  // [4] env_m
  // [3] mal_l
  // [2] fault_l
  // [1] mal_s
  // [0] fault_s
  typedef logic [8:0] exc_flags_t;

  typedef logic [3:0] cause_t;   // Trap cause code, interrupt bit not stored.

endpackage

`default_nettype wire
